//--- Makefile
TOP = fifo_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

//--- all.f
design/fifo_pkg.sv
design/fifo_status_signal.sv
design/fifo_ram.sv
design/fifo_level_monitor.sv
design/fifo_top.sv
tb/fifo_scoreboard.sv
tb/fifo_tb.sv

//--- design/fifo_level_monitor.sv
`timescale 1ns/100ps

module fifo_level_monitor #(
    parameter int DEPTH              = fifo_pkg::FIFO_DEPTH_DEFAULT,
    parameter int ALMOST_FULL_LEVEL  = fifo_pkg::ALMOST_FULL_DEFAULT,
    parameter int ALMOST_EMPTY_LEVEL = fifo_pkg::ALMOST_EMPTY_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    // Pointer pair from the status stage
    input  fifo_pkg::fifo_addr_t  wr_addr,
    input  fifo_pkg::fifo_addr_t  rd_addr,
    input  logic                  wr_lap,
    input  logic                  rd_lap,
    // One cycle behind the pointers
    output fifo_pkg::fifo_level_t level,
    output logic                  almost_full,
    output logic                  almost_empty
);

    import fifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////////////////////

    // Constants in count width
    localparam fifo_level_t DEPTH_LEVEL = fifo_level_t'(DEPTH);
    localparam fifo_level_t AF_LEVEL    = fifo_level_t'(ALMOST_FULL_LEVEL);
    localparam fifo_level_t AE_LEVEL    = fifo_level_t'(ALMOST_EMPTY_LEVEL);

    fifo_level_t level_next;
    fifo_level_t wr_ext;
    fifo_level_t rd_ext;

    // Zero-extend addresses to the count width
    assign wr_ext = fifo_level_t'(wr_addr);
    assign rd_ext = fifo_level_t'(rd_addr);

    always_comb begin
        if (wr_lap == rd_lap) begin
            // Same lap, writer is ahead in the array
            level_next = wr_ext - rd_ext;
        end else begin
            // Writer has wrapped once more than the reader
            level_next = DEPTH_LEVEL - rd_ext + wr_ext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            level        <= '0;
            almost_full  <= 1'b0;
            almost_empty <= 1'b1;
        end else begin
            level        <= level_next;
            // Thresholds are inclusive
            almost_full  <= (level_next >= AF_LEVEL);
            almost_empty <= (level_next <= AE_LEVEL);
        end
    end

    // Count never runs past the array size
    a_level_bounded: assert property (
        @(posedge clk) disable iff (reset)
        level <= DEPTH_LEVEL
    );

endmodule

//--- design/fifo_pkg.sv
package fifo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // One stored word
    localparam int DATA_WIDTH  = 16;
    // RAM address, limits the depth to 16 entries
    localparam int ADDR_WIDTH  = 4;
    // Occupancy count from 0 up to the full depth
    localparam int LEVEL_WIDTH = ADDR_WIDTH + 1;

    typedef logic [DATA_WIDTH-1:0]  fifo_data_t;
    typedef logic [ADDR_WIDTH-1:0]  fifo_addr_t;
    typedef logic [LEVEL_WIDTH-1:0] fifo_level_t;

    ////////////////////////////////////////////////////////////////////////////
    // Default configuration
    ////////////////////////////////////////////////////////////////////////////

    // Entries in the RAM, not a power of two
    localparam int FIFO_DEPTH_DEFAULT   = 13;

    // almost_full set at or above this level
    localparam int ALMOST_FULL_DEFAULT  = 11;

    // almost_empty set at or below this level
    localparam int ALMOST_EMPTY_DEFAULT = 2;

endpackage

//--- design/fifo_ram.sv
`timescale 1ns/100ps

module fifo_ram #(
    parameter int DEPTH = fifo_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    // Write port
    input  logic                 write_accept,
    input  fifo_pkg::fifo_addr_t wr_addr,
    input  fifo_pkg::fifo_data_t wr_data,
    // Read port
    input  logic                 read_accept,
    input  fifo_pkg::fifo_addr_t rd_addr,
    output fifo_pkg::fifo_data_t rd_data,
    output logic                 rd_valid
);

    import fifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Highest address the array holds
    localparam fifo_addr_t LAST_ADDR = fifo_addr_t'(DEPTH - 1);

    // DEPTH entries only since codes above DEPTH-1 never occur
    fifo_data_t mem [0:DEPTH-1];

    // Write on an accepted strobe
    always_ff @(posedge clk) begin
        if (write_accept) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read that holds its data between reads
    always_ff @(posedge clk) begin
        if (read_accept) begin
            rd_data <= mem[rd_addr];
        end
    end

    // One-cycle pulse alongside the new data
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_accept;
        end
    end

    // Accesses stay inside the array
    a_access_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (!write_accept || (wr_addr <= LAST_ADDR)) && (!read_accept || (rd_addr <= LAST_ADDR))
    );

endmodule

//--- design/fifo_status_signal.sv
`timescale 1ns/100ps

module fifo_status_signal #(
    parameter int DEPTH = fifo_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    // Single-cycle strobes without handshake
    input  logic                 write,
    input  logic                 read,
    // Registered pointer state
    output fifo_pkg::fifo_addr_t wr_addr,
    output fifo_pkg::fifo_addr_t rd_addr,
    output logic                 wr_lap,
    output logic                 rd_lap,
    // Strobes that got past the full and empty gate
    output logic                 write_accept,
    output logic                 read_accept,
    output logic                 full,
    output logic                 empty,
    // Sticky until reset
    output logic                 overflow,
    output logic                 underflow
);

    import fifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer wrap
    ////////////////////////////////////////////////////////////////////////////

    // Highest valid RAM address
    localparam fifo_addr_t LAST_ADDR = fifo_addr_t'(DEPTH - 1);

    // Step to the next entry and back to zero after the last one
    function automatic fifo_addr_t next_addr(input fifo_addr_t addr);
        return (addr == LAST_ADDR) ? '0 : addr + fifo_addr_t'(1);
    endfunction

    logic addr_equal;

    ////////////////////////////////////////////////////////////////////////////
    // Status and acceptance
    ////////////////////////////////////////////////////////////////////////////

    // On equal addresses the lap bits tell full from empty
    assign addr_equal = (wr_addr == rd_addr);
    assign full       = addr_equal && (wr_lap != rd_lap);
    assign empty      = addr_equal && (wr_lap == rd_lap);

    // Refuse writes when full and reads when empty
    assign write_accept = write && !full;
    assign read_accept  = read && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    // Write side
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr <= '0;
            wr_lap  <= 1'b0;
        end else if (write_accept) begin
            wr_addr <= next_addr(wr_addr);
            // Lap flips on the wrap
            if (wr_addr == LAST_ADDR) begin
                wr_lap <= !wr_lap;
            end
        end
    end

    // Read side in the same scheme
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_addr <= '0;
            rd_lap  <= 1'b0;
        end else if (read_accept) begin
            rd_addr <= next_addr(rd_addr);
            if (rd_addr == LAST_ADDR) begin
                rd_lap <= !rd_lap;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Error flags
    ////////////////////////////////////////////////////////////////////////////

    // Set one edge after a refused strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (write && full) begin
                overflow <= 1'b1;
            end
            if (read && empty) begin
                underflow <= 1'b1;
            end
        end
    end

    // Reader stays behind the writer and at most one lap back
    a_pointer_order: assert property (
        @(posedge clk) disable iff (reset)
        (wr_lap == rd_lap) ? (wr_addr >= rd_addr) : (wr_addr <= rd_addr)
    );

    // Wrap keeps both addresses inside the RAM
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (wr_addr <= LAST_ADDR) && (rd_addr <= LAST_ADDR)
    );

endmodule

//--- design/fifo_top.sv
`timescale 1ns/100ps

module fifo_top #(
    parameter int DEPTH              = fifo_pkg::FIFO_DEPTH_DEFAULT,
    parameter int ALMOST_FULL_LEVEL  = fifo_pkg::ALMOST_FULL_DEFAULT,
    parameter int ALMOST_EMPTY_LEVEL = fifo_pkg::ALMOST_EMPTY_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    // Producer side
    input  logic                  write,
    input  fifo_pkg::fifo_data_t  wr_data,
    // Consumer side, data must be taken on the rd_valid pulse
    input  logic                  read,
    output fifo_pkg::fifo_data_t  rd_data,
    output logic                  rd_valid,
    // Status
    output logic                  full,
    output logic                  empty,
    output fifo_pkg::fifo_level_t level,
    output logic                  almost_full,
    output logic                  almost_empty,
    // Sticky errors
    output logic                  overflow,
    output logic                  underflow
);

    import fifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////

    // Pointer state from the status stage
    fifo_addr_t wr_addr;
    fifo_addr_t rd_addr;
    logic       wr_lap;
    logic       rd_lap;

    // Accepted strobes toward the RAM
    logic       write_accept;
    logic       read_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and status stage
    ////////////////////////////////////////////////////////////////////////////

    fifo_status_signal #(
        .DEPTH (DEPTH)
    ) fifo_status_signal_inst (
        .clk          (clk),
        .reset        (reset),
        .write        (write),
        .read         (read),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .wr_lap       (wr_lap),
        .rd_lap       (rd_lap),
        .write_accept (write_accept),
        .read_accept  (read_accept),
        .full         (full),
        .empty        (empty),
        .overflow     (overflow),
        .underflow    (underflow)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage stage
    ////////////////////////////////////////////////////////////////////////////

    fifo_ram #(
        .DEPTH (DEPTH)
    ) fifo_ram_inst (
        .clk          (clk),
        .reset        (reset),
        .write_accept (write_accept),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .read_accept  (read_accept),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Level stage
    ////////////////////////////////////////////////////////////////////////////

    // Works from the registered pointers, adds one more cycle
    fifo_level_monitor #(
        .DEPTH              (DEPTH),
        .ALMOST_FULL_LEVEL  (ALMOST_FULL_LEVEL),
        .ALMOST_EMPTY_LEVEL (ALMOST_EMPTY_LEVEL)
    ) fifo_level_monitor_inst (
        .clk          (clk),
        .reset        (reset),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .wr_lap       (wr_lap),
        .rd_lap       (rd_lap),
        .level        (level),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

endmodule

//--- tb/fifo_scoreboard.sv
`timescale 1ns/100ps

module fifo_scoreboard #(
    parameter int DEPTH              = fifo_pkg::FIFO_DEPTH_DEFAULT,
    parameter int ALMOST_FULL_LEVEL  = fifo_pkg::ALMOST_FULL_DEFAULT,
    parameter int ALMOST_EMPTY_LEVEL = fifo_pkg::ALMOST_EMPTY_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    // All DUT ports observed
    input  logic                  write,
    input  fifo_pkg::fifo_data_t  wr_data,
    input  logic                  read,
    input  fifo_pkg::fifo_data_t  rd_data,
    input  logic                  rd_valid,
    input  logic                  full,
    input  logic                  empty,
    input  fifo_pkg::fifo_level_t level,
    input  logic                  almost_full,
    input  logic                  almost_empty,
    input  logic                  overflow,
    input  logic                  underflow,
    // Totals for the closing report
    output int                    error_count,
    output int                    reads_checked
);

    import fifo_pkg::*;

    localparam fifo_level_t AF_EXP = fifo_level_t'(ALMOST_FULL_LEVEL);
    localparam fifo_level_t AE_EXP = fifo_level_t'(ALMOST_EMPTY_LEVEL);

    fifo_data_t  model_q[$];
    int          model_count;
    // Expected values one edge behind the model
    fifo_level_t level_exp;
    fifo_data_t  data_exp;
    logic        valid_exp;
    logic        overflow_exp;
    logic        underflow_exp;
    logic        reset_d;
    logic        write_ok;
    logic        read_ok;

    initial begin
        error_count   = 0;
        reads_checked = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        error_count = error_count + 1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Acceptance from the model count alone
    assign write_ok = write && (model_count != DEPTH);
    assign read_ok  = read && (model_count != 0);

    always @(posedge clk) begin
        reset_d <= reset;
        if (rd_valid) begin
            reads_checked = reads_checked + 1;
        end
        if (reset) begin
            model_q.delete();
            model_count   <= 0;
            level_exp     <= '0;
            valid_exp     <= 1'b0;
            overflow_exp  <= 1'b0;
            underflow_exp <= 1'b0;
        end else begin
            // Pop before push so a read at full takes the old head
            if (read_ok) begin
                data_exp <= model_q.pop_front();
            end
            if (write_ok) begin
                model_q.push_back(wr_data);
            end
            model_count   <= model_count + int'(write_ok) - int'(read_ok);
            // Level stage works from last cycle's pointers
            level_exp     <= fifo_level_t'(model_count);
            valid_exp     <= read_ok;
            overflow_exp  <= overflow_exp || (write && !write_ok);
            underflow_exp <= underflow_exp || (read && !read_ok);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_data_order: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (rd_data == data_exp))
        else report_mismatch("rd_data", 32'(rd_data), 32'(data_exp));

    // Also catches a pulse from a refused read
    a_rd_valid: assert property (@(posedge clk) disable iff (reset)
        rd_valid == valid_exp)
        else report_mismatch("rd_valid", 32'(rd_valid), 32'(valid_exp));

    a_full: assert property (@(posedge clk) disable iff (reset)
        full == (model_count == DEPTH))
        else report_mismatch("full", 32'(full), 32'(model_count == DEPTH));

    a_empty: assert property (@(posedge clk) disable iff (reset)
        empty == (model_count == 0))
        else report_mismatch("empty", 32'(empty), 32'(model_count == 0));

    a_level: assert property (@(posedge clk) disable iff (reset)
        level == level_exp)
        else report_mismatch("level", 32'(level), 32'(level_exp));

    a_almost_full: assert property (@(posedge clk) disable iff (reset)
        almost_full == (level_exp >= AF_EXP))
        else report_mismatch("almost_full", 32'(almost_full), 32'(level_exp >= AF_EXP));

    a_almost_empty: assert property (@(posedge clk) disable iff (reset)
        almost_empty == (level_exp <= AE_EXP))
        else report_mismatch("almost_empty", 32'(almost_empty), 32'(level_exp <= AE_EXP));

    // Sticky flags cleared only by reset
    a_overflow: assert property (@(posedge clk) disable iff (reset)
        overflow == overflow_exp)
        else report_mismatch("overflow", 32'(overflow), 32'(overflow_exp));

    a_underflow: assert property (@(posedge clk) disable iff (reset)
        underflow == underflow_exp)
        else report_mismatch("underflow", 32'(underflow), 32'(underflow_exp));

    // Any edge that follows a reset edge
    a_reset_values: assert property (@(posedge clk)
        reset_d |-> ({full, empty, rd_valid, overflow, underflow, almost_full,
                      almost_empty, level} == {7'b0100001, 5'd0}))
        else report_mismatch({"{full,empty,rd_valid,overflow,underflow,",
                              "almost_full,almost_empty,level}"},
                             32'({full, empty, rd_valid, overflow, underflow, almost_full,
                                  almost_empty, level}),
                             32'({7'b0100001, 5'd0}));

endmodule

//--- tb/fifo_tb.sv
`timescale 1ns/100ps

module fifo_tb;

    import fifo_pkg::*;

    localparam int DEPTH         = FIFO_DEPTH_DEFAULT;
    localparam int PERIOD        = 20;
    localparam int RESET_CYCLES  = 3;
    // Phase lengths in clock cycles
    localparam int FILL_CYCLES   = DEPTH + 3 + 1;
    localparam int RANDOM_CYCLES = 400;
    localparam int EDGE_CYCLES   = 2 * DEPTH + 8;
    localparam int TOTAL_CYCLES  = 2 * RESET_CYCLES + 2 * FILL_CYCLES + RANDOM_CYCLES
                                 + EDGE_CYCLES + 4;

    logic        clk;
    logic        reset;
    logic        write;
    fifo_data_t  wr_data;
    logic        read;
    fifo_data_t  rd_data;
    logic        rd_valid;
    logic        full;
    logic        empty;
    fifo_level_t level;
    logic        almost_full;
    logic        almost_empty;
    logic        overflow;
    logic        underflow;
    int          error_count;
    int          reads_checked;
    integer      seed = 32'hce474a6a;

    fifo_top #(
        .DEPTH (DEPTH)
    ) fifo_top_inst (
        .clk          (clk),
        .reset        (reset),
        .write        (write),
        .wr_data      (wr_data),
        .read         (read),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .full         (full),
        .empty        (empty),
        .level        (level),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (overflow),
        .underflow    (underflow)
    );

    // Watches the same ports
    fifo_scoreboard #(
        .DEPTH (DEPTH)
    ) fifo_scoreboard_inst (
        .clk           (clk),
        .reset         (reset),
        .write         (write),
        .wr_data       (wr_data),
        .read          (read),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .full          (full),
        .empty         (empty),
        .level         (level),
        .almost_full   (almost_full),
        .almost_empty  (almost_empty),
        .overflow      (overflow),
        .underflow     (underflow),
        .error_count   (error_count),
        .reads_checked (reads_checked)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // One cycle of strobes with fresh random data
    task automatic drive(input logic w, input logic r);
        @(posedge clk);
        write   <= w;
        read    <= r;
        wr_data <= fifo_data_t'($random(seed));
    endtask

    task automatic hold_reset();
        reset <= 1'b1;
        write <= 1'b0;
        read  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Three writes past full
    task automatic fill_past_full();
        for (int i = 0; i < DEPTH + 3; i++) begin
            drive(1'b1, 1'b0);
        end
        drive(1'b0, 1'b0);
    endtask

    task automatic drain_past_empty();
        for (int i = 0; i < DEPTH + 3; i++) begin
            drive(1'b0, 1'b1);
        end
        drive(1'b0, 1'b0);
    endtask

    // Unbiased strobes, count walks between full and empty
    task automatic random_traffic();
        logic [31:0] rnd;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd = $random(seed);
            drive(rnd[0], rnd[1]);
        end
    endtask

    task automatic simultaneous_at_edges();
        // Empty first, whatever the random phase left
        repeat (DEPTH + 1) drive(1'b0, 1'b1);
        // At empty only the write goes in, then both
        drive(1'b1, 1'b1);
        drive(1'b1, 1'b1);
        repeat (DEPTH) drive(1'b1, 1'b0);
        // At full only the read goes out, then both
        drive(1'b1, 1'b1);
        drive(1'b1, 1'b1);
        repeat (3) drive(1'b0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset   <= 1'b1;
        write   <= 1'b0;
        read    <= 1'b0;
        wr_data <= '0;
        hold_reset();
        fill_past_full();
        drain_past_empty();
        // Clears the sticky flags before mixed traffic
        hold_reset();
        random_traffic();
        simultaneous_at_edges();
        // Level lags two edges
        repeat (4) @(posedge clk);
        $display("Errors: %0d, reads checked: %0d", error_count, reads_checked);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog at twice the planned run length
    initial begin
        #(2 * TOTAL_CYCLES * PERIOD);
        $display("Timeout: run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
